// ==== Bender.yml ====
# 16-point row DCT with a self-checking testbench
package:
  name: dct_row

dependencies: {}

export_include_dirs:
  - hw

sources:
  # design, packages first
  - include_dirs:
      - hw
    files:
      - hw/dct_types_pkg.sv
      - hw/dct_coef_pkg.sv
      - hw/dct_butterfly_if.sv
      - hw/dct_input_butterfly.sv
      - hw/dct_even_part.sv
      - hw/dct_odd_part.sv
      - hw/dct_row_top.sv

  # testbench, top module dct_row_tb
  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/dct_row_tb.sv

// ==== build.f ====
+incdir+hw
+incdir+verif
hw/dct_types_pkg.sv
hw/dct_coef_pkg.sv
hw/dct_butterfly_if.sv
hw/dct_input_butterfly.sv
hw/dct_even_part.sv
hw/dct_odd_part.sv
hw/dct_row_top.sv
verif/dct_row_tb.sv

// ==== hw/dct_butterfly_if.sv ====
// first-stage butterfly bundle, driven by the input butterfly and read by the even and odd parts
`timescale 1ns/1ps
`include "dct_cfg.svh"

interface dct_butterfly_if;
    import dct_types_pkg::*;

    // high for one cycle when sums and diffs hold a new row
    logic   valid;

    // x[n] + x[15-n], never negative
    // held as a 9 bit pattern, readers widen it with zeros
    bfly1_t sums  [`DCT_PAIRS];

    // x[n] - x[15-n], true signed value
    bfly1_t diffs [`DCT_PAIRS];

    // input butterfly side
    modport src (
        output valid,
        output sums,
        output diffs
    );

    // even and odd part side
    modport dst (
        input valid,
        input sums,
        input diffs
    );

endinterface

// ==== hw/dct_cfg.svh ====
// row DCT sizing macros, included by the packages and every RTL file that sizes a vector
`ifndef DCT_CFG_SVH
`define DCT_CFG_SVH

// samples per image row
`define DCT_POINTS 16

// butterfly pairs n and points-1-n
`define DCT_PAIRS (`DCT_POINTS / 2)

// unsigned pixel sample
`define DCT_SAMPLE_W 8

// integer cosine constant, scaled by about 23
`define DCT_COEF_W 7

// signed output coefficient
`define DCT_OUT_W 11

// arithmetic right shift before the output cut
`define DCT_FRAC_SHIFT 6

// accumulator, wide enough for 16 samples at full weight
`define DCT_ACC_W 20

`endif

// ==== hw/dct_coef_pkg.sv ====
// integer cosine table and weight rule of the row DCT, imported by the even and odd parts
`include "dct_cfg.svh"

package dct_coef_pkg;

    typedef logic [`DCT_COEF_W-1:0] cos_t;
    // index 0 to points inclusive
    typedef logic [$clog2(`DCT_POINTS + 1)-1:0] cos_idx_t;

    // C[j] ~ cos(j*pi/32) * 23, C[0] is the dc weight
    localparam cos_t cos_table [`DCT_POINTS + 1] = '{
        16, 23, 22, 22, 21, 20, 19, 17, 16, 14, 13, 11, 9, 7, 4, 2, 0
    };

    // signed weight of sample n in coefficient k
    // only called with constant arguments, so it folds away in synthesis
    function automatic int cos_weight(input int k, input int n);
        int       m;
        cos_idx_t idx;
        // phase in units of pi/32, one full turn is 64
        m = ((2 * n + 1) * k) % (4 * `DCT_POINTS);
        // cosine is even around a full turn
        if (m > 2 * `DCT_POINTS) begin
            m = 4 * `DCT_POINTS - m;
        end
        // past a quarter turn the cosine goes negative
        if (m > `DCT_POINTS) begin
            idx = cos_idx_t'(2 * `DCT_POINTS - m);
            return -int'(cos_table[idx]);
        end
        idx = cos_idx_t'(m);
        return int'(cos_table[idx]);
    endfunction

endpackage

// ==== hw/dct_even_part.sv ====
// even DCT half: builds X[0], X[2] .. X[14] from the pair sums and registers them with the strobe
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dct_even_part (
    input  logic                     clk,
    input  logic                     arst_n,
    dct_butterfly_if.dst             bfly,
    output logic                     even_valid,
    output dct_types_pkg::coef_out_t even_coefs [`DCT_PAIRS]
);
    import dct_types_pkg::*;
    import dct_coef_pkg::*;

    // second butterfly, pairs n and 7-n of the sums
    bfly2_t sum2  [`DCT_PAIRS / 2];
    bfly2_t diff2 [`DCT_PAIRS / 2];
    // third butterfly, pairs n and 3-n of sum2
    bfly3_t sum3  [`DCT_PAIRS / 4];
    bfly3_t diff3 [`DCT_PAIRS / 4];
    // fourth butterfly, feeds X[0] and X[8]
    acc_t   dc_sum;
    acc_t   dc_diff;
    // weighted sums, index j holds X[2j]
    acc_t   acc_even [`DCT_PAIRS];

    // sum paths never go negative, so they widen with zeros
    // diff paths are true signed values and widen with the sign
    always_comb begin
        for (int n = 0; n < `DCT_PAIRS / 2; n++) begin
            sum2[n]  = bfly2_t'($unsigned(bfly.sums[n]))
                     + bfly2_t'($unsigned(bfly.sums[`DCT_PAIRS - 1 - n]));
            diff2[n] = bfly2_t'($unsigned(bfly.sums[n]))
                     - bfly2_t'($unsigned(bfly.sums[`DCT_PAIRS - 1 - n]));
        end
    end

    always_comb begin
        for (int n = 0; n < `DCT_PAIRS / 4; n++) begin
            sum3[n]  = bfly3_t'($unsigned(sum2[n]))
                     + bfly3_t'($unsigned(sum2[`DCT_PAIRS / 2 - 1 - n]));
            diff3[n] = bfly3_t'($unsigned(sum2[n]))
                     - bfly3_t'($unsigned(sum2[`DCT_PAIRS / 2 - 1 - n]));
        end
    end

    // last butterfly done at full width
    // sum3 reaches 2040 and needs the zero msb
    assign dc_sum  = acc_t'($unsigned(sum3[0])) + acc_t'($unsigned(sum3[1]));
    assign dc_diff = acc_t'($unsigned(sum3[0])) - acc_t'($unsigned(sum3[1]));

    always_comb begin
        // X[0] and X[8], single weight of 16
        acc_even[0] = acc_t'(cos_weight(0, 0)) * dc_sum;
        acc_even[4] = acc_t'(cos_weight(8, 0)) * dc_diff;

        // X[4] and X[12], rotation by C[4] and C[12]
        acc_even[2] = acc_t'(cos_weight(4, 0)) * acc_t'(diff3[0])
                    + acc_t'(cos_weight(4, 1)) * acc_t'(diff3[1]);
        acc_even[6] = acc_t'(cos_weight(12, 0)) * acc_t'(diff3[0])
                    + acc_t'(cos_weight(12, 1)) * acc_t'(diff3[1]);

        // X[2], X[6], X[10], X[14] from the second-stage diffs
        // weights are C[2], C[6], C[10], C[14] with rule signs
        for (int m = 0; m < `DCT_PAIRS / 2; m++) begin
            acc_even[2 * m + 1] = '0;
            for (int n = 0; n < `DCT_PAIRS / 2; n++) begin
                acc_even[2 * m + 1] = acc_even[2 * m + 1]
                                    + acc_t'(cos_weight(4 * m + 2, n)) * acc_t'(diff2[n]);
            end
        end
    end

    // output strobe, also serves the odd half
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            even_valid <= 1'b0;
        end else begin
            even_valid <= bfly.valid;
        end
    end

    // coefficients read zero until the first row lands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int j = 0; j < `DCT_PAIRS; j++) begin
                even_coefs[j] <= '0;
            end
        end else if (bfly.valid) begin
            for (int j = 0; j < `DCT_PAIRS; j++) begin
                even_coefs[j] <= scale_out(acc_even[j]);
            end
        end
    end

endmodule

// ==== hw/dct_input_butterfly.sv ====
// first DCT stage: slices a row into samples and registers the pair sums and differences
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dct_input_butterfly (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  dct_types_pkg::row_in_t in_row,
    dct_butterfly_if.src           bfly
);
    import dct_types_pkg::*;

    // unpacked samples, x[0] from the top byte
    sample_t samples [`DCT_POINTS];
    // combinational butterfly results
    bfly1_t  sum_d   [`DCT_PAIRS];
    bfly1_t  diff_d  [`DCT_PAIRS];

    always_comb begin
        for (int i = 0; i < `DCT_POINTS; i++) begin
            samples[i] = in_row[(`DCT_POINTS - 1 - i) * `DCT_SAMPLE_W +: `DCT_SAMPLE_W];
        end
    end

    // pair n with its mirror 15-n
    always_comb begin
        for (int n = 0; n < `DCT_PAIRS; n++) begin
            // one extra bit so 255 + 255 keeps its carry
            sum_d[n]  = bfly1_t'({1'b0, samples[n]} + {1'b0, samples[`DCT_POINTS - 1 - n]});
            // same width, the borrow lands in the sign bit
            diff_d[n] = bfly1_t'({1'b0, samples[n]} - {1'b0, samples[`DCT_POINTS - 1 - n]});
        end
    end

    // strobe follows the input by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bfly.valid <= 1'b0;
        end else begin
            bfly.valid <= in_valid;
        end
    end

    // butterfly data only moves on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int n = 0; n < `DCT_PAIRS; n++) begin
                bfly.sums[n]  <= sum_d[n];
                bfly.diffs[n] <= diff_d[n];
            end
        end
    end

endmodule

// ==== hw/dct_odd_part.sv ====
// odd DCT half: builds X[1], X[3] .. X[15] from the pair differences and registers them
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dct_odd_part (
    input  logic                     clk,
    input  logic                     arst_n,
    dct_butterfly_if.dst             bfly,
    output dct_types_pkg::coef_out_t odd_coefs [`DCT_PAIRS]
);
    import dct_types_pkg::*;
    import dct_coef_pkg::*;

    // index j holds X[2j+1]
    acc_t acc_odd [`DCT_PAIRS];

    // for odd k the mirror sample carries the negated weight
    // so each coefficient is a dot product over the eight diffs
    //
    // every weight is plus or minus an odd table entry
    //   X[1]  leans on C[1], C[3] .. C[15]
    //   X[15] uses the same set in reverse with alternating sign
    //
    // weights are fixed numbers after unrolling
    // each product becomes a small shift-add tree
    always_comb begin
        for (int j = 0; j < `DCT_PAIRS; j++) begin
            acc_odd[j] = '0;
            for (int n = 0; n < `DCT_PAIRS; n++) begin
                // diffs are signed, widen with the sign
                acc_odd[j] = acc_odd[j]
                           + acc_t'(cos_weight(2 * j + 1, n)) * acc_t'(bfly.diffs[n]);
            end
        end
    end

    // largest magnitude is 8 * 255 * 23
    // that stays inside 17 bits, well under the accumulator width

    // loads on the same strobe as the even half
    // the even half owns the output valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int j = 0; j < `DCT_PAIRS; j++) begin
                odd_coefs[j] <= '0;
            end
        end else if (bfly.valid) begin
            for (int j = 0; j < `DCT_PAIRS; j++) begin
                // shift by 6, keep 11 bits
                odd_coefs[j] <= scale_out(acc_odd[j]);
            end
        end
    end

endmodule

// ==== hw/dct_row_top.sv ====
// 16-point row DCT top: pipelines one row per cycle and returns packed coefficients 2 cycles later
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dct_row_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  dct_types_pkg::row_in_t  in_row,
    output logic                    out_valid,
    output dct_types_pkg::row_out_t out_coefs
);
    import dct_types_pkg::*;

    // X[0], X[2] .. X[14]
    coef_out_t even_coefs [`DCT_PAIRS];
    // X[1], X[3] .. X[15]
    coef_out_t odd_coefs  [`DCT_PAIRS];

    // stage 1 to stage 2 bundle
    dct_butterfly_if bfly ();

    // cycle 1, pair sums and diffs
    dct_input_butterfly u_input_butterfly (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_row   (in_row),
        .bfly     (bfly.src)
    );

    // cycle 2, even coefficients and the output strobe
    dct_even_part u_even_part (
        .clk        (clk),
        .arst_n     (arst_n),
        .bfly       (bfly.dst),
        .even_valid (out_valid),
        .even_coefs (even_coefs)
    );

    // cycle 2, odd coefficients
    dct_odd_part u_odd_part (
        .clk       (clk),
        .arst_n    (arst_n),
        .bfly      (bfly.dst),
        .odd_coefs (odd_coefs)
    );

    // interleave back into index order, X[0] in the top field
    always_comb begin
        for (int j = 0; j < `DCT_PAIRS; j++) begin
            out_coefs[(`DCT_POINTS - 1 - 2 * j) * `DCT_OUT_W +: `DCT_OUT_W] = even_coefs[j];
            out_coefs[(`DCT_POINTS - 2 - 2 * j) * `DCT_OUT_W +: `DCT_OUT_W] = odd_coefs[j];
        end
    end

endmodule

// ==== hw/dct_types_pkg.sv ====
// data-path vector types of the row DCT stages, imported by the interface and RTL modules
`include "dct_cfg.svh"

package dct_types_pkg;

    // one unsigned input pixel
    typedef logic [`DCT_SAMPLE_W-1:0] sample_t;

    // first butterfly, pair sum or difference
    typedef logic signed [`DCT_SAMPLE_W:0] bfly1_t;
    // second butterfly on the sums
    typedef logic signed [`DCT_SAMPLE_W+1:0] bfly2_t;
    // third butterfly on the second-stage sums
    typedef logic signed [`DCT_SAMPLE_W+2:0] bfly3_t;

    // weighted sum before the output cut
    typedef logic signed [`DCT_ACC_W-1:0] acc_t;
    typedef logic signed [`DCT_OUT_W-1:0] coef_out_t;

    // x[0] sits in the top byte
    typedef logic [`DCT_POINTS*`DCT_SAMPLE_W-1:0] row_in_t;
    // X[0] sits in the top field
    typedef logic [`DCT_POINTS*`DCT_OUT_W-1:0] row_out_t;

    // shift right by the fraction and keep the low output bits
    // same as taking bits 16 down to 6 of the sum
    function automatic coef_out_t scale_out(input acc_t acc);
        return coef_out_t'(acc >>> `DCT_FRAC_SHIFT);
    endfunction

endpackage

// ==== verif/dct_ref_model.svh ====
// reference model of the row DCT by the cosine rule, included inside the testbench module
`ifndef DCT_REF_MODEL_SVH
`define DCT_REF_MODEL_SVH

// scaled cosine constants C[0] .. C[16], C[0] is the dc weight
localparam int model_cos [17] = '{
    16, 23, 22, 22, 21, 20, 19, 17, 16, 14, 13, 11, 9, 7, 4, 2, 0
};

// signed weight of sample n in coefficient k
function automatic int cos_rule_weight(input int k, input int n);
    int m;
    // phase in steps of pi/32, a full turn is 64 steps
    m = ((2 * n + 1) * k) % 64;
    // fold the second half turn back
    if (m > 32) begin
        m = 64 - m;
    end
    // second quarter turn gives a negative cosine
    if (m > 16) begin
        return -model_cos[32 - m];
    end
    return model_cos[m];
endfunction

// one coefficient as a plain dot product over all sixteen samples
function automatic coef_out_t expected_coef(input row_in_t row, input int k);
    int acc;
    int sample;
    acc = 0;
    for (int n = 0; n < `DCT_POINTS; n++) begin
        // x[0] sits in the top byte, zero extended
        sample = int'(row[(`DCT_POINTS - 1 - n) * `DCT_SAMPLE_W +: `DCT_SAMPLE_W]);
        acc = acc + sample * cos_rule_weight(k, n);
    end
    // arithmetic shift, then keep the low output bits
    return coef_out_t'(acc >>> `DCT_FRAC_SHIFT);
endfunction

// whole packed output row, X[0] in the top field
function automatic row_out_t expected_row(input row_in_t row);
    row_out_t coefs;
    coefs = '0;
    for (int k = 0; k < `DCT_POINTS; k++) begin
        coefs[(`DCT_POINTS - 1 - k) * `DCT_OUT_W +: `DCT_OUT_W] = expected_coef(row, k);
    end
    return coefs;
endfunction

`endif

// ==== verif/dct_row_tb.sv ====
// self-checking testbench of the row DCT top that runs directed and random rows against the model
`timescale 1ns/1ps
`include "dct_cfg.svh"

module dct_row_tb;
    import dct_types_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;
    // in_valid to out_valid in whole cycles
    localparam int latency      = 2;
    localparam int random_rows  = 300;
    localparam int gap_rows     = 60;
    localparam int max_gap      = 4;
    // all tests together take about 550 cycles
    localparam int max_cycles   = 1000;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    row_in_t  in_row;
    logic     out_valid;
    row_out_t out_coefs;

    // rows in flight oldest first with the cycle they were sent
    row_out_t expected_q   [$];
    int       sent_cycle_q [$];
    int       cycle_count;

    `include "dct_ref_model.svh"

    dct_row_top dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .out_valid (out_valid),
        .out_coefs (out_coefs)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at cycle %0d", cycle_count);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h",
                                    name, expected, actual));
        end
    endtask

    // field by field so a failure names the coefficient
    task automatic compare_row(input row_out_t expected);
        for (int k = 0; k < `DCT_POINTS; k++) begin
            check_value($sformatf("out_coefs X[%0d]", k),
                        32'(expected[(`DCT_POINTS - 1 - k) * `DCT_OUT_W +: `DCT_OUT_W]),
                        32'(out_coefs[(`DCT_POINTS - 1 - k) * `DCT_OUT_W +: `DCT_OUT_W]));
        end
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            stop_on_error("timeout, the tests did not finish within the cycle limit");
        end
    end

    // outputs only move on the rising edge so read them on the falling one
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (sent_cycle_q.size() == 0) begin
                stop_on_error("out_valid was high while no row was in flight");
            end else begin
                check_value("out_valid latency", latency, cycle_count - sent_cycle_q.pop_front());
                compare_row(expected_q.pop_front());
            end
        end else if (sent_cycle_q.size() != 0 && cycle_count - sent_cycle_q[0] > latency) begin
            stop_on_error("out_valid never came for a row that was sent");
        end
    end

    function automatic row_in_t random_row();
        row_in_t row;
        // four 32 bit words fill the 128 bit row
        for (int w = 0; w < 4; w++) begin
            row[w * 32 +: 32] = $urandom();
        end
        return row;
    endfunction

    // one row with its strobe and its expected result queued for the monitor
    task automatic send_row(input row_in_t row, input row_out_t expected);
        @(negedge clk);
        in_valid = 1'b1;
        in_row   = row;
        expected_q.push_back(expected);
        sent_cycle_q.push_back(cycle_count);
    endtask

    // strobe low with junk on the data lines
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
            in_row   = random_row();
        end
    endtask

    // let the pipe empty and then watch a few quiet cycles
    task automatic finish_burst();
        idle_cycles(1);
        while (sent_cycle_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(3);
    endtask

    task automatic idle_stays_quiet();
        repeat (20) begin
            @(negedge clk);
            check_value("out_valid", 0, 32'(out_valid));
        end
    endtask

    // dc only so X[0] is sample * 256 >> 6 and the rest is zero
    task automatic constant_rows();
        sample_t  levels [5];
        row_out_t expected;
        levels = '{8'd0, 8'd255, 8'd1, 8'd128, sample_t'($urandom())};
        foreach (levels[i]) begin
            expected = '0;
            expected[(`DCT_POINTS - 1) * `DCT_OUT_W +: `DCT_OUT_W] =
                coef_out_t'((int'(levels[i]) * 256) >>> `DCT_FRAC_SHIFT);
            send_row({`DCT_POINTS{levels[i]}}, expected);
        end
        finish_burst();
    endtask

    task automatic directed_rows();
        int      spots [6];
        row_in_t row;
        spots = '{0, 3, 7, 8, 12, 15};
        // single impulse at several positions
        foreach (spots[i]) begin
            row = '0;
            row[(`DCT_POINTS - 1 - spots[i]) * `DCT_SAMPLE_W +: `DCT_SAMPLE_W] = 8'd200;
            send_row(row, expected_row(row));
        end
        // alternating 0/255 and its inverse
        for (int i = 0; i < `DCT_POINTS; i++) begin
            row[(`DCT_POINTS - 1 - i) * `DCT_SAMPLE_W +: `DCT_SAMPLE_W] = (i % 2) ? 8'd255 : 8'd0;
        end
        send_row(row, expected_row(row));
        send_row(~row, expected_row(~row));
        // ascending ramp 0 .. 255
        for (int i = 0; i < `DCT_POINTS; i++) begin
            row[(`DCT_POINTS - 1 - i) * `DCT_SAMPLE_W +: `DCT_SAMPLE_W] = sample_t'(i * 17);
        end
        send_row(row, expected_row(row));
        finish_burst();
    endtask

    task automatic back_to_back_rows();
        row_in_t row;
        for (int i = 0; i < random_rows; i++) begin
            row = random_row();
            send_row(row, expected_row(row));
        end
        finish_burst();
    endtask

    task automatic rows_with_gaps();
        row_in_t row;
        for (int i = 0; i < gap_rows; i++) begin
            row = random_row();
            send_row(row, expected_row(row));
            idle_cycles($urandom_range(max_gap, 0));
        end
        finish_burst();
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_row      = '0;
        cycle_count = 0;
        void'($urandom(71));
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        idle_stays_quiet();
        constant_rows();
        directed_rows();
        back_to_back_rows();
        rows_with_gaps();

        $display(">>> PASS");
        $finish;
    end

endmodule
